// ==== hdl/lsu_pkg.sv ====
// load-store unit shared definitions

package lsu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;  // data and address width
  localparam int unsigned BE_W   = 4;   // byte lanes per word
  localparam int unsigned CNT_W  = 2;   // outstanding counter width

  // max outstanding bus transactions, one slot in write-back
  localparam logic [CNT_W-1:0] LSU_DEPTH = CNT_W'(1);

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // access size, code 2'b11 behaves as byte
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // load extension mode
  typedef enum logic [1:0] {
    SE_ZERO = 2'b00,  // zero fill
    SE_SIGN = 2'b01,  // replicate msb
    SE_ONES = 2'b10   // ones fill
  } sign_ext_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  // one request from the execute stage
  typedef struct packed {
    logic              we;           // store when set
    data_type_e        dtype;
    sign_ext_e         sign_ext;
    logic [DATA_W-1:0] wdata;        // store data, unrotated
    logic [DATA_W-1:0] operand_a;    // base address
    logic [DATA_W-1:0] operand_b;    // offset, added when use_incr
    logic              use_incr;
    logic              second_half;  // second access of a misaligned pair
  } ex_req_t;

  // obi address phase
  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // what write-back needs to shape the read data
  typedef struct packed {
    data_type_e dtype;
    logic [1:0] offset;      // low address bits
    sign_ext_e  sign_ext;
    logic       we;
    logic       first_half;  // first access of a misaligned pair
  } wb_ctrl_t;

endpackage

// ==== hdl/lsu_req_format.sv ====
// load-store request formatter

module lsu_req_format (
  input  lsu_pkg::ex_req_t  ex_req_i,      // request from execute
  output lsu_pkg::bus_req_t bus_req_o,     // address phase to the bus
  output logic [1:0]        offset_o,      // byte offset in the word
  output logic              misaligned_o   // first half of a word-crossing access
);

  logic [lsu_pkg::DATA_W-1:0] addr_int;   // unaligned byte address
  logic [1:0]                 offset;     // addr_int[1:0]
  logic [lsu_pkg::BE_W-1:0]   be;         // lane enables
  logic [lsu_pkg::DATA_W-1:0] wdata_rot;  // store data moved to its lanes

  //////////////////////////////////////////////////
  // address generation
  //////////////////////////////////////////////////

  // a + b for reg+imm forms, a alone for post-increment forms
  assign addr_int = ex_req_i.use_incr ? (ex_req_i.operand_a + ex_req_i.operand_b)
                                      : ex_req_i.operand_a;
  assign offset   = addr_int[1:0];
  assign offset_o = offset;

  // crossing detection, only the first access can cross
  always_comb begin
    misaligned_o = 1'b0;
    if (!ex_req_i.second_half) begin
      case (ex_req_i.dtype)
        lsu_pkg::DT_WORD: misaligned_o = (offset != 2'b00);  // any nonzero offset
        lsu_pkg::DT_HALF: misaligned_o = (offset == 2'b11);  // upper byte spills over
        default:          misaligned_o = 1'b0;               // bytes never cross
      endcase
    end
  end

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (ex_req_i.dtype)
      lsu_pkg::DT_WORD: begin
        if (!ex_req_i.second_half) begin
          // upper lanes from the offset
          case (offset)
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // remaining lower lanes in the next word
          case (offset)
            2'b00:   be = 4'b0000;  // never issued
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
      lsu_pkg::DT_HALF: begin
        if (!ex_req_i.second_half) begin
          case (offset)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;  // low byte only, high byte goes next
          endcase
        end else begin
          be = 4'b0001;  // spilled byte lands in lane 0
        end
      end
      default: begin
        be = 4'b0001 << offset;  // single lane
      end
    endcase
  end

  //////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////

  // rotate left by offset bytes, wrapped bytes serve the second half
  always_comb begin
    case (offset)
      2'b00:   wdata_rot = ex_req_i.wdata;
      2'b01:   wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  // second half goes to the word-aligned next address
  always_comb begin
    if (ex_req_i.second_half) begin
      bus_req_o.addr = {addr_int[lsu_pkg::DATA_W-1:2], 2'b00};
    end else begin
      bus_req_o.addr = addr_int;
    end
    bus_req_o.we    = ex_req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata_rot;
  end

endmodule

// ==== hdl/lsu_txn_ctrl.sv ====
// load-store transaction control

module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // execute wants an access
  input  logic data_gnt_i,      // bus took the address phase
  input  logic data_rvalid_i,   // bus response
  output logic data_req_o,      // obi request
  output logic lsu_ready_ex_o,  // execute may advance
  output logic lsu_ready_wb_o,  // write-back may advance
  output logic ctrl_update_o,   // request accepted this cycle
  output logic busy_o
);

  logic [lsu_pkg::CNT_W-1:0] cnt_q;       // outstanding transactions
  logic [lsu_pkg::CNT_W-1:0] cnt_d;
  logic                      count_up;    // accepted address phase
  logic                      count_down;  // response returned

  // hold off while the write-back slot is full, keeps rvalid off the req path
  assign data_req_o = data_req_ex_i && (cnt_q < lsu_pkg::LSU_DEPTH);

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  //////////////////////////////////////////////////
  // ready and busy
  //////////////////////////////////////////////////

  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;  // idle or finishing

  // execute advances on the grant of its own request
  assign lsu_ready_ex_o = !data_req_ex_i ? 1'b1 : count_up;

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;  // capture wb control

  assign busy_o = (cnt_q != '0) || data_req_o;

  //////////////////////////////////////////////////
  // outstanding counter
  //////////////////////////////////////////////////

  always_comb begin
    unique case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // idle, or issue and retire together
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// ==== hdl/lsu_load_align.sv ====
// load data alignment and extension

module lsu_load_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ctrl_update_i,    // request accepted
  input  lsu_pkg::ex_req_t           ex_req_i,
  input  logic [1:0]                 offset_i,         // from the formatter
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,
  output logic [lsu_pkg::DATA_W-1:0] data_rdata_ex_o   // aligned load result
);

  lsu_pkg::wb_ctrl_t          wb_d;
  lsu_pkg::wb_ctrl_t          wb_q;       // access now in write-back
  logic [lsu_pkg::DATA_W-1:0] rdata_q;    // raw first half, or last result
  logic [lsu_pkg::DATA_W-1:0] word_al;    // word with misaligned merge
  logic [15:0]                half_al;    // selected halfword
  logic [7:0]                 byte_al;    // selected byte
  logic                       fill;       // extension bit
  logic [lsu_pkg::DATA_W-1:0] rdata_ext;  // final load value

  // fill bit for the upper bits
  function automatic logic ext_bit(lsu_pkg::sign_ext_e mode, logic msb);
    case (mode)
      lsu_pkg::SE_ZERO: ext_bit = 1'b0;
      lsu_pkg::SE_ONES: ext_bit = 1'b1;
      lsu_pkg::SE_SIGN: ext_bit = msb;
      default:          ext_bit = msb;  // unused code acts as sign
    endcase
  endfunction

  //////////////////////////////////////////////////
  // write-back control
  //////////////////////////////////////////////////

  always_comb begin
    wb_d.dtype    = ex_req_i.dtype;
    wb_d.offset   = offset_i;
    wb_d.sign_ext = ex_req_i.sign_ext;
    wb_d.we       = ex_req_i.we;
    // first access of a crossing word or halfword
    wb_d.first_half = !ex_req_i.second_half &&
                      (((ex_req_i.dtype == lsu_pkg::DT_WORD) && (offset_i != 2'b00)) ||
                       ((ex_req_i.dtype == lsu_pkg::DT_HALF) && (offset_i == 2'b11)));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (ctrl_update_i) begin
      wb_q <= wb_d;  // moves with the request into wb
    end
  end

  //////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////

  // crossing words take the stored upper bytes below the new lower bytes
  always_comb begin
    case (wb_q.offset)
      2'b00:   word_al = data_rdata_i;
      2'b01:   word_al = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   word_al = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_al = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (wb_q.offset)
      2'b00:   half_al = data_rdata_i[15:0];
      2'b01:   half_al = data_rdata_i[23:8];
      2'b10:   half_al = data_rdata_i[31:16];
      default: half_al = {data_rdata_i[7:0], rdata_q[31:24]};  // assembled over two words
    endcase
  end

  assign byte_al = 8'(data_rdata_i >> {wb_q.offset, 3'b000});  // lane pick

  //////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////

  always_comb begin
    case (wb_q.dtype)
      lsu_pkg::DT_WORD: begin
        fill      = 1'b0;  // nothing to extend
        rdata_ext = word_al;
      end
      lsu_pkg::DT_HALF: begin
        fill      = ext_bit(wb_q.sign_ext, half_al[15]);
        rdata_ext = {{16{fill}}, half_al};
      end
      default: begin
        fill      = ext_bit(wb_q.sign_ext, byte_al[7]);
        rdata_ext = {{24{fill}}, byte_al};
      end
    endcase
  end

  // keep raw word for the merge, otherwise hold the result
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !wb_q.we) begin
      rdata_q <= wb_q.first_half ? data_rdata_i : rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // live in rvalid cycle

endmodule

// ==== hdl/lsu_top.sv ====
// load-store unit top

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // execute stage
  input  logic                       data_req_ex_i,
  input  lsu_pkg::ex_req_t           ex_req_i,
  output logic [lsu_pkg::DATA_W-1:0] data_rdata_ex_o,
  output logic                       data_misaligned_o,  // issue second half next
  output logic                       lsu_ready_ex_o,
  output logic                       lsu_ready_wb_o,
  output logic                       busy_o,

  // obi data bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  output lsu_pkg::bus_req_t          bus_req_o,
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i
);

  logic [1:0] offset;       // byte offset of the current request
  logic       ctrl_update;  // acceptance strobe

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  lsu_req_format u_req_format (
    .ex_req_i     (ex_req_i),
    .bus_req_o    (bus_req_o),
    .offset_o     (offset),
    .misaligned_o (data_misaligned_o)
  );

  lsu_txn_ctrl u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .ctrl_update_o  (ctrl_update),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  lsu_load_align u_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .ex_req_i        (ex_req_i),
    .offset_i        (offset),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

endmodule

// ==== dv/tb_obi_mem.sv ====
// obi memory model with random stalls

module tb_obi_mem #(
  parameter int MEM_WORDS = 64,  // word count, index from addr[7:2]
  parameter int MAX_STALL = 3,   // longest grant stall in cycles
  parameter int MAX_LAT   = 4    // longest grant to rvalid delay
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  lsu_pkg::bus_req_t          bus_req_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [lsu_pkg::DATA_W-1:0] mem [MEM_WORDS];  // read by the testbench
  logic [7:0]                 stall_q;          // cycles waited for grant
  logic [7:0]                 stall_lim_q;      // stall drawn for this request
  logic                       pend_q;           // response owed
  logic [7:0]                 lat_q;            // cycles left before rvalid
  logic [lsu_pkg::DATA_W-1:0] rd_q;             // read data captured at grant
  logic [5:0]                 idx;

  assign idx   = bus_req_i.addr[7:2];
  assign gnt_o = req_i && (stall_q >= stall_lim_q);  // grant once the stall is over

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q     <= '0;
      stall_lim_q <= '0;
      pend_q      <= 1'b0;
      lat_q       <= '0;
      rd_q        <= '0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= '0;  // cleared memory
      end
    end else begin
      rvalid_o <= 1'b0;
      if (pend_q) begin
        if (lat_q == '0) begin
          rvalid_o <= 1'b1;  // response for loads and stores
          rdata_o  <= rd_q;
          pend_q   <= 1'b0;
        end else begin
          lat_q <= lat_q - 1'b1;
        end
      end
      if (req_i && gnt_o) begin
        pend_q      <= 1'b1;
        lat_q       <= 8'($urandom % MAX_LAT);
        rd_q        <= mem[idx];
        stall_q     <= '0;
        stall_lim_q <= 8'($urandom % (MAX_STALL + 1));  // next request's stall
        if (bus_req_i.we) begin
          for (int b = 0; b < lsu_pkg::BE_W; b++) begin
            if (bus_req_i.be[b]) begin
              mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];  // enabled lanes only
            end
          end
        end
      end else if (req_i) begin
        stall_q <= stall_q + 1'b1;
      end
    end
  end

endmodule

// ==== dv/lsu_assertions.sv ====
// transaction protocol assertions

module lsu_assertions (
  input logic                      clk,
  input logic                      rst_n,
  input logic [lsu_pkg::CNT_W-1:0] cnt_q,
  input logic                      data_req_o,
  input logic                      data_gnt_i,
  input logic                      data_rvalid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;  // failed assertion count

  // write-back holds a single slot
  a_cnt_depth: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= lsu_pkg::LSU_DEPTH)
    else begin
      fail_cnt++;
      $error("outstanding counter above depth");
    end

  // responses only for issued requests
  a_rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0))
    else begin
      fail_cnt++;
      $error("rvalid with nothing outstanding");
    end

  // obi request held until granted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> data_req_o)
    else begin
      fail_cnt++;
      $error("request dropped before grant");
    end

  a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({data_req_o, data_gnt_i, data_rvalid_i}))
    else begin
      fail_cnt++;
      $error("unknown bus handshake");
    end

endmodule

bind lsu_txn_ctrl lsu_assertions u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .cnt_q         (cnt_q),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i)
);

// ==== dv/tb_lsu.sv ====
// load-store unit testbench

module tb_lsu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RST_CYCLES = 10;
  localparam int MAX_STALL  = 3;
  localparam int MAX_LAT    = 4;

  logic                       clk;
  logic                       rst_n;
  logic                       data_req_ex;
  lsu_pkg::ex_req_t           ex_req;
  logic [lsu_pkg::DATA_W-1:0] data_rdata_ex;
  logic                       data_misaligned;
  logic                       lsu_ready_ex;
  logic                       lsu_ready_wb;
  logic                       busy;
  logic                       data_req;
  logic                       data_gnt;
  lsu_pkg::bus_req_t          bus_req;
  logic                       data_rvalid;
  logic [lsu_pkg::DATA_W-1:0] data_rdata;

  // stimulus table, one entry per file line
  string       t_name [$];
  logic [31:0] t_we [$];
  logic [31:0] t_size [$];
  logic [31:0] t_sext [$];
  logic [31:0] t_opa [$];
  logic [31:0] t_opb [$];
  logic [31:0] t_incr [$];
  logic [31:0] t_wdata [$];
  logic [31:0] t_mis [$];
  logic [31:0] t_be [$];
  logic [31:0] t_exp [$];

  int          cycle_cnt;
  int          timeout_lim;

  lsu_top UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_req_ex_i     (data_req_ex),
    .ex_req_i          (ex_req),
    .data_rdata_ex_o   (data_rdata_ex),
    .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o    (lsu_ready_ex),
    .lsu_ready_wb_o    (lsu_ready_wb),
    .busy_o            (busy),
    .data_req_o        (data_req),
    .data_gnt_i        (data_gnt),
    .bus_req_o         (bus_req),
    .data_rvalid_i     (data_rvalid),
    .data_rdata_i      (data_rdata)
  );

  tb_obi_mem #(.MEM_WORDS(64), .MAX_STALL(MAX_STALL), .MAX_LAT(MAX_LAT)) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (data_req),
    .bus_req_i (bus_req),
    .gnt_o     (data_gnt),
    .rvalid_o  (data_rvalid),
    .rdata_o   (data_rdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped at first failure");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_lim) begin
      fail_run("timeout, the LSU did not finish within the cycle limit");
    end
  end

  // bound protocol checker
  always @(negedge clk) begin
    if (UUT.u_txn_ctrl.u_assert.fail_cnt != 0) begin
      fail_run("a bus protocol assertion failed");
    end
  end

  //////////////////////////////////////////////////
  // expected values from the access rules
  //////////////////////////////////////////////////

  function automatic logic [31:0] expected_addr(input int i, input bit second);
    logic [31:0] a;
    a = t_opa[i] + (second ? 32'd4 : 32'd0);  // execute advances operand_a
    if (t_incr[i][0]) a = a + t_opb[i];
    if (second) a = {a[31:2], 2'b00};
    return a;
  endfunction

  // lower lanes left over from the first half
  function automatic logic [3:0] second_be(input logic [1:0] size, input logic [1:0] off);
    if (size == 2'd0) return 4'((5'd1 << off) - 5'd1);
    return 4'b0001;
  endfunction

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] f [11];
    fd = $fopen("dv/lsu_stim.txt", "r");
    if (fd == 0) fail_run("could not open the stimulus file dv/lsu_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, f[1], f[2], f[3],
                  f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
      if (n != 11) fail_run($sformatf("malformed stimulus line: %s", line));
      t_name.push_back(name);
      t_we.push_back(f[1]);
      t_size.push_back(f[2]);
      t_sext.push_back(f[3]);
      t_opa.push_back(f[4]);
      t_opb.push_back(f[5]);
      t_incr.push_back(f[6]);
      t_wdata.push_back(f[7]);
      t_mis.push_back(f[8]);
      t_be.push_back(f[9]);
      t_exp.push_back(f[10]);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic issue_access(input int i, input bit second);
    logic [31:0] exp_addr;
    logic [31:0] first_addr;
    logic [3:0]  exp_be;
    logic        exp_mis;
    exp_addr   = expected_addr(i, second);
    first_addr = expected_addr(i, 1'b0);
    exp_be     = second ? second_be(t_size[i][1:0], first_addr[1:0])
                        : t_be[i][3:0];
    exp_mis    = second ? 1'b0 : t_mis[i][0];
    @(negedge clk);
    data_req_ex          = 1'b1;
    ex_req.we            = t_we[i][0];
    ex_req.dtype         = lsu_pkg::data_type_e'(t_size[i][1:0]);
    ex_req.sign_ext      = lsu_pkg::sign_ext_e'(t_sext[i][1:0]);
    ex_req.wdata         = t_wdata[i];
    ex_req.operand_a     = t_opa[i] + (second ? 32'd4 : 32'd0);
    ex_req.operand_b     = t_opb[i];
    ex_req.use_incr      = t_incr[i][0];
    ex_req.second_half   = second;
    do @(posedge clk); while (!lsu_ready_ex);  // acceptance edge
    assert (data_req && data_gnt)
      else fail_run($sformatf("execute ready without a granted request in %s", t_name[i]));
    assert (bus_req.addr == exp_addr)
      else fail_run($sformatf("error %s addr expected %h actual %h",
                              t_name[i], exp_addr, bus_req.addr));
    assert (bus_req.be == exp_be)
      else fail_run($sformatf("error %s be expected %h actual %h",
                              t_name[i], exp_be, bus_req.be));
    assert (data_misaligned == exp_mis)
      else fail_run($sformatf("error %s misaligned expected %h actual %h",
                              t_name[i], exp_mis, data_misaligned));
  endtask

  task automatic run_test(input int i);
    logic [31:0] word;
    logic [31:0] first_addr;
    first_addr = expected_addr(i, 1'b0);
    issue_access(i, 1'b0);
    if (t_mis[i][0]) issue_access(i, 1'b1);  // second half of the pair
    @(negedge clk);
    data_req_ex = 1'b0;
    do @(posedge clk); while (!data_rvalid);  // last response
    assert (lsu_ready_wb)
      else fail_run($sformatf("write-back not ready on the response in %s", t_name[i]));
    if (t_we[i][0]) begin
      word = u_mem.mem[first_addr[7:2]];
      assert (word == t_exp[i])
        else fail_run($sformatf("error %s mem expected %h actual %h",
                                t_name[i], t_exp[i], word));
    end else begin
      assert (data_rdata_ex == t_exp[i])
        else fail_run($sformatf("error %s rdata expected %h actual %h",
                                t_name[i], t_exp[i], data_rdata_ex));
      @(posedge clk);
      // result held once rvalid drops
      assert (data_rdata_ex == t_exp[i])
        else fail_run($sformatf("error %s held rdata expected %h actual %h",
                                t_name[i], t_exp[i], data_rdata_ex));
    end
  endtask

  initial begin
    void'($urandom(32'hdaa27481));
    cycle_cnt   = 0;
    timeout_lim = 1000;
    rst_n       = 1'b0;
    data_req_ex = 1'b0;
    ex_req      = '0;
    load_stim();
    timeout_lim = t_name.size() * 2 * (MAX_STALL + MAX_LAT + 10) + RST_CYCLES;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    assert (!data_req && !busy && !data_misaligned && lsu_ready_wb)
      else fail_run("outputs not in their idle state after reset");
    for (int i = 0; i < t_name.size(); i++) begin
      run_test(i);
    end
    @(posedge clk);
    assert (!busy) else fail_run("LSU still busy after the last response");
    @(negedge clk);
    if (UUT.u_txn_ctrl.u_assert.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== dv/lsu_stim.txt ====
# name we size(0 w,1 h,2 b) sext(0 zero,1 sign,2 ones) opa opb incr wdata
# exp_misaligned exp_be exp (store: memory word after the store, load: result)
sw_incr      1 0 0 0000000c 00000004 1 876543a1 0 f 876543a1
lw_noincr    0 0 0 00000010 00000040 0 00000000 0 f 876543a1
lw_incr      0 0 0 00000008 00000008 1 00000000 0 f 876543a1
sb_off0      1 2 0 00000020 00000000 0 000000c3 0 1 000000c3
sb_off1      1 2 0 00000021 00000000 0 0000005a 0 2 00005ac3
sh_off2      1 1 0 00000022 00000000 0 0000f08e 0 c f08e5ac3
sh_off1      1 1 0 00000031 00000000 0 00001234 0 6 00123400
sb_off3      1 2 0 00000033 00000000 0 000000ff 0 8 ff123400
sh_off0      1 1 0 00000034 00000000 0 0000abcd 0 3 0000abcd
lb_zero_0    0 2 0 00000020 00000000 0 00000000 0 1 000000c3
lb_sign_0    0 2 1 00000020 00000000 0 00000000 0 1 ffffffc3
lb_ones_1    0 2 2 00000021 00000000 0 00000000 0 2 ffffff5a
lb_sign_1    0 2 1 00000021 00000000 0 00000000 0 2 0000005a
lb_sign_2    0 2 1 00000022 00000000 0 00000000 0 4 ffffff8e
lb_zero_3    0 2 0 00000023 00000000 0 00000000 0 8 000000f0
lh_sign_0    0 1 1 00000020 00000000 0 00000000 0 3 00005ac3
lh_sign_2    0 1 1 00000022 00000000 0 00000000 0 c fffff08e
lh_ones_1    0 1 2 00000031 00000000 0 00000000 0 6 ffff1234
lh_zero_2    0 1 0 00000032 00000000 0 00000000 0 c 0000ff12
lw_mis1      0 0 0 00000031 00000000 0 00000000 1 e cdff1234
lw_mis2      0 0 0 00000032 00000000 0 00000000 1 c abcdff12
lw_mis3      0 0 0 00000033 00000000 0 00000000 1 8 00abcdff
lh_mis3_sign 0 1 1 00000033 00000000 0 00000000 1 8 ffffcdff
lh_mis3_incr 0 1 0 00000030 00000003 1 00000000 1 8 0000cdff

// ==== list.f ====
hdl/lsu_pkg.sv
hdl/lsu_req_format.sv
hdl/lsu_txn_ctrl.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
dv/tb_obi_mem.sv
dv/lsu_assertions.sv
dv/tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
